/* rtl/frame_pkg.sv */
// frame buffer package
// widths, limits and shared types for the store-and-forward frame buffer
package frame_pkg;

    // beat payload
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // default fifo depth is 2**FIFO_ADDR_WIDTH beats
    localparam int FIFO_ADDR_WIDTH = 4;

    // longest frame the length checker passes as good
    localparam int MAX_FRAME_BEATS = 12;

    // statistics counter width
    localparam int STAT_WIDTH = 16;

    // beat index within a frame, saturates at all ones
    typedef logic [4:0] beat_cnt_t;

    // payload types
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [KEEP_WIDTH-1:0] keep_t;

    // frame event counter
    typedef logic [STAT_WIDTH-1:0] stat_cnt_t;

endpackage

/* rtl/frame_len_check.sv */
// frame length checker
// counts beats within each frame and flags the last beat of any frame
// longer than MAX_FRAME_BEATS as bad, zero latency on the beat path
module frame_len_check
    import frame_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // control bits of the incoming beat
    input  logic in_valid,
    input  logic in_last,
    input  logic in_user,
    output logic in_ready,

    // toward the frame fifo
    input  logic fifo_ready,
    output logic fifo_user
);

    // index of the current beat within its frame
    beat_cnt_t beat_cnt;

    logic beat_xfer;
    logic too_long;

    // ready comes straight back from the fifo
    assign in_ready = fifo_ready;

    // beat moves on this edge
    assign beat_xfer = in_valid & fifo_ready;

    // index 0 is the first beat, so index MAX_FRAME_BEATS is one too many
    assign too_long = (beat_cnt >= beat_cnt_t'(MAX_FRAME_BEATS));

    // error flag only matters on the last beat, fifo decides there
    assign fifo_user = in_user | (in_last & too_long);

    // beat index counter
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (beat_xfer) begin
            if (in_last) begin
                // next beat starts a new frame
                beat_cnt <= '0;
            end else if (beat_cnt != '1) begin
                // hold at all ones, still counts as too long
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/frame_fifo.sv */
// frame fifo
// writes each frame speculatively and commits it on a good last beat,
// rolls back bad frames and drops frames that outgrow the memory,
// registered read stage with valid/ready, status pulses one cycle late
module frame_fifo
    import frame_pkg::*;
#(
    parameter int addr_width = FIFO_ADDR_WIDTH
) (
    input  logic  clk,
    input  logic  rst,

    // write side
    input  data_t in_data,
    input  keep_t in_keep,
    input  logic  in_valid,
    input  logic  in_last,
    input  logic  in_user,
    output logic  in_ready,

    // read side
    output data_t out_data,
    output keep_t out_keep,
    output logic  out_valid,
    output logic  out_last,
    input  logic  out_ready,

    // frame outcome pulses
    output logic  good_frame,
    output logic  bad_frame,
    output logic  overflow
);

    // pointers carry one extra bit to tell full from empty
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] wr_ptr_cur;
    logic [addr_width:0] rd_ptr;

    // beat storage
    data_t mem_data [2**addr_width];
    keep_t mem_keep [2**addr_width];
    logic  mem_last [2**addr_width];

    logic full;
    logic full_cur;
    logic empty;
    logic accept;
    logic write;
    logic read;

    // speculative write a whole depth ahead of read
    assign full = (wr_ptr_cur[addr_width] != rd_ptr[addr_width]) &&
                  (wr_ptr_cur[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    // current frame fills the whole memory by itself
    // stays set until its last beat since wr_ptr_cur stops moving
    assign full_cur = (wr_ptr_cur[addr_width] != wr_ptr[addr_width]) &&
                      (wr_ptr_cur[addr_width-1:0] == wr_ptr[addr_width-1:0]);

    // only committed beats are readable
    assign empty = (wr_ptr == rd_ptr);

    // an overflowing frame is swallowed to its end, never stalled
    assign in_ready = ~full | full_cur;

    assign accept = in_valid & in_ready;
    assign write  = accept & ~full_cur;

    // refill output register when empty or being taken
    assign read = (out_ready | ~out_valid) & ~empty;

    // write pointers and frame outcome
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            wr_ptr_cur <= '0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
            if (accept) begin
                if (full_cur) begin
                    // dropping, overflow wins over a bad flag
                    if (in_last) begin
                        wr_ptr_cur <= wr_ptr;
                        overflow   <= 1'b1;
                    end
                end else if (in_last && in_user) begin
                    // roll back the bad frame
                    wr_ptr_cur <= wr_ptr;
                    bad_frame  <= 1'b1;
                end else if (in_last) begin
                    // commit including this beat
                    wr_ptr     <= wr_ptr_cur + 1'b1;
                    wr_ptr_cur <= wr_ptr_cur + 1'b1;
                    good_frame <= 1'b1;
                end else begin
                    wr_ptr_cur <= wr_ptr_cur + 1'b1;
                end
            end
        end
    end

    // memory write at the speculative pointer
    always_ff @(posedge clk) begin
        if (write) begin
            mem_data[wr_ptr_cur[addr_width-1:0]] <= in_data;
            mem_keep[wr_ptr_cur[addr_width-1:0]] <= in_keep;
            mem_last[wr_ptr_cur[addr_width-1:0]] <= in_last;
        end
    end

    // read pointer and output valid
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else if (out_ready || !out_valid) begin
            out_valid <= ~empty;
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // output payload register
    always_ff @(posedge clk) begin
        if (read) begin
            out_data <= mem_data[rd_ptr[addr_width-1:0]];
            out_keep <= mem_keep[rd_ptr[addr_width-1:0]];
            out_last <= mem_last[rd_ptr[addr_width-1:0]];
        end
    end

endmodule

/* rtl/frame_stats.sv */
// frame statistics
// saturating counters for good, bad and overflowed frames,
// each bumps on the edge after its pulse
module frame_stats
    import frame_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // one-cycle outcome pulses from the fifo
    input  logic      good_frame,
    input  logic      bad_frame,
    input  logic      overflow,

    // running totals
    output stat_cnt_t good_count,
    output stat_cnt_t bad_count,
    output stat_cnt_t overflow_count
);

    // index 0 good, 1 bad, 2 overflow
    logic [2:0] event_pulse;
    stat_cnt_t  count [3];

    assign event_pulse = {overflow, bad_frame, good_frame};

    // same saturating counter for every outcome
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                // hold at max instead of wrapping
                if (event_pulse[i] && count[i] != '1) begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    assign good_count     = count[0];
    assign bad_count      = count[1];
    assign overflow_count = count[2];

endmodule

/* rtl/frame_buffer_top.sv */
// frame buffer top
// length checker feeding a store-and-forward frame fifo,
// with frame outcome statistics on the side
module frame_buffer_top
    import frame_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // input beat stream
    input  data_t     in_data,
    input  keep_t     in_keep,
    input  logic      in_valid,
    input  logic      in_last,
    input  logic      in_user,
    output logic      in_ready,

    // output beat stream, committed frames only
    output data_t     out_data,
    output keep_t     out_keep,
    output logic      out_valid,
    output logic      out_last,
    input  logic      out_ready,

    // frame totals
    output stat_cnt_t good_count,
    output stat_cnt_t bad_count,
    output stat_cnt_t overflow_count
);

    logic fifo_ready;
    logic fifo_user;
    logic good_frame;
    logic bad_frame;
    logic overflow;

    // checker only needs the control bits
    frame_len_check len_check_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_user   (in_user),
        .in_ready  (in_ready),
        .fifo_ready(fifo_ready),
        .fifo_user (fifo_user)
    );

    // data, keep, valid and last bypass the checker
    frame_fifo #(
        .addr_width(FIFO_ADDR_WIDTH)
    ) fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_user   (fifo_user),
        .in_ready  (fifo_ready),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready),
        .good_frame(good_frame),
        .bad_frame (bad_frame),
        .overflow  (overflow)
    );

    frame_stats stats_i (
        .clk           (clk),
        .rst           (rst),
        .good_frame    (good_frame),
        .bad_frame     (bad_frame),
        .overflow      (overflow),
        .good_count    (good_count),
        .bad_count     (bad_count),
        .overflow_count(overflow_count)
    );

endmodule

/* verif/frame_buffer_tb.sv */
// frame buffer testbench
// drives random frames from a galois lfsr and classifies each one in a model
// then compares good beats at the output and the frame counts at the end
module frame_buffer_tb
    import frame_pkg::*;
#(
    parameter int seed = 9007
);

    localparam int num_frames     = 400;
    localparam int max_len        = 20;
    localparam int fifo_depth     = 2**FIFO_ADDR_WIDTH;
    localparam int timeout_cycles = num_frames * max_len * 4 + 1000;

    // right shifting form of x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic      clk = 1'b0;
    logic      rst;
    data_t     in_data;
    keep_t     in_keep;
    logic      in_valid;
    logic      in_last;
    logic      in_user;
    logic      in_ready;
    data_t     out_data;
    keep_t     out_keep;
    logic      out_valid;
    logic      out_last;
    logic      out_ready;
    stat_cnt_t good_count;
    stat_cnt_t bad_count;
    stat_cnt_t overflow_count;

    // separate streams for stimulus and output stalls
    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;

    // expected output beats of good frames only
    data_t exp_data [$];
    keep_t exp_keep [$];
    logic  exp_last [$];

    int exp_good;
    int exp_bad;
    int exp_over;
    int stall_cycles;
    int cycle_count;

    frame_buffer_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .in_data       (in_data),
        .in_keep       (in_keep),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .in_user       (in_user),
        .in_ready      (in_ready),
        .out_data      (out_data),
        .out_keep      (out_keep),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .out_ready     (out_ready),
        .good_count    (good_count),
        .bad_count     (bad_count),
        .overflow_count(overflow_count)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] take_bits(inout logic [31:0] state, input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits  = {bits[62:0], state[0]};
            state = lfsr_step(state);
        end
        return bits;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_keep(input string name, input keep_t exp, input keep_t act);
        if (exp !== act) begin
            $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // single-bit outputs such as last, valid and ready
    task automatic check_last(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error at %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input stat_cnt_t exp, input stat_cnt_t act);
        if (exp !== act) begin
            $display("Error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // hold the beat until the edge where ready is seen high
    task automatic send_beat(input data_t d, input keep_t k, input logic last, input logic user);
        logic done;
        done     = 1'b0;
        in_data  = d;
        in_keep  = k;
        in_last  = last;
        in_user  = user;
        in_valid = 1'b1;
        while (!done) begin
            // in_ready comes from fifo state only and holds until the edge
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    // output stalls with short random gaps and occasional long holds
    initial begin : ready_driver
        int stall_left;
        out_ready  = 1'b0;
        stall_left = 0;
        ready_lfsr = seed ^ 32'h5bd1e995;
        forever begin
            @(posedge clk);
            #1;
            if (stall_left > 0) begin
                out_ready  = 1'b0;
                stall_left = stall_left - 1;
            end else if (int'(take_bits(ready_lfsr, 5)) == 0) begin
                // long enough to fill the memory behind it
                out_ready  = 1'b0;
                stall_left = 8 + int'(take_bits(ready_lfsr, 5));
            end else begin
                out_ready = (int'(take_bits(ready_lfsr, 2)) != 0);
            end
        end
    end

    // scoreboard samples mid-cycle where the handshake is stable
    always @(negedge clk) begin
        if (!rst && in_valid && !in_ready) begin
            stall_cycles = stall_cycles + 1;
        end
        if (!rst && out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                $display("output beat at %0t with no good frame expected", $time);
                abort_run();
            end else begin
                check_data("out_data", exp_data.pop_front(), out_data);
                check_keep("out_keep", exp_keep.pop_front(), out_keep);
                check_last("out_last", exp_last.pop_front(), out_last);
            end
        end
    end

    // run limit sized for the worst case frame mix
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout after %0d cycles, frames did not drain", cycle_count);
            abort_run();
        end
    end

    initial begin : stimulus
        int    len;
        logic  bad;
        logic  good;
        logic  last;
        data_t d;
        keep_t k;
        rst          = 1'b1;
        in_data      = '0;
        in_keep      = '0;
        in_valid     = 1'b0;
        in_last      = 1'b0;
        in_user      = 1'b0;
        exp_good     = 0;
        exp_bad      = 0;
        exp_over     = 0;
        stall_cycles = 0;
        cycle_count  = 0;
        stim_lfsr    = seed;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle state straight after reset
        check_last("out_valid", 1'b0, out_valid);
        check_last("in_ready", 1'b1, in_ready);
        check_count("good_count", '0, good_count);
        check_count("bad_count", '0, bad_count);
        check_count("overflow_count", '0, overflow_count);

        for (int f = 0; f < num_frames; f++) begin
            len  = int'(take_bits(stim_lfsr, 5)) % max_len + 1;
            bad  = (int'(take_bits(stim_lfsr, 3)) == 0);
            good = 1'b0;
            // overflow takes priority over a bad flag or too long
            if (len > fifo_depth) begin
                exp_over = exp_over + 1;
            end else if (bad || len > MAX_FRAME_BEATS) begin
                exp_bad = exp_bad + 1;
            end else begin
                exp_good = exp_good + 1;
                good     = 1'b1;
            end
            for (int b = 0; b < len; b++) begin
                d    = data_t'(take_bits(stim_lfsr, DATA_WIDTH));
                k    = keep_t'(take_bits(stim_lfsr, KEEP_WIDTH));
                last = (b == len - 1);
                if (good) begin
                    exp_data.push_back(d);
                    exp_keep.push_back(k);
                    exp_last.push_back(last);
                end
                // random input gaps
                while (int'(take_bits(stim_lfsr, 2)) == 0) begin
                    @(posedge clk);
                    #1;
                end
                send_beat(d, k, last, bad);
            end
        end

        // wait for every expected beat to leave the output
        while (exp_data.size() != 0) begin
            @(posedge clk);
        end

        // pulse one edge after the last beat and the counter on the next
        @(posedge clk);
        #1;
        check_count("good_count", stat_cnt_t'(exp_good), good_count);
        check_count("bad_count", stat_cnt_t'(exp_bad), bad_count);
        check_count("overflow_count", stat_cnt_t'(exp_over), overflow_count);

        // nothing left behind the last expected beat
        check_last("out_valid", 1'b0, out_valid);

        if (stall_cycles == 0) begin
            $display("in_ready never fell, back-pressure was not exercised");
            abort_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* vlog.f */
rtl/frame_pkg.sv
rtl/frame_len_check.sv
rtl/frame_fifo.sv
rtl/frame_stats.sv
rtl/frame_buffer_top.sv
verif/frame_buffer_tb.sv

/* Makefile */
# Verilator build and run for the frame buffer

VERILATOR ?= verilator
TOP       ?= frame_buffer_tb
RTL_TOP   ?= frame_buffer_top
SEED      ?= 9007
LOG       ?= sim.log
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --top-module $(TOP) -Gseed=$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
